// File: Bender.yml
package:
  name: opl3_operator

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/opl3_reg_pkg.sv
      - hw/opl3_wave_pkg.sv
      - hw/opl3_reg_decode.sv
      - hw/opl3_phase_gen.sv
      - hw/opl3_wave_out.sv
      - hw/opl3_operator.sv
  - target: test
    include_dirs:
      - hw
      - tb
    files:
      - tb/tb_opl3_operator.sv

// File: compile.f
+incdir+hw
+incdir+tb
hw/opl3_reg_pkg.sv
hw/opl3_wave_pkg.sv
hw/opl3_reg_decode.sv
hw/opl3_phase_gen.sv
hw/opl3_wave_out.sv
hw/opl3_operator.sv
tb/tb_opl3_operator.sv

// File: hw/opl3_macros.svh
`ifndef OPL3_MACROS_SVH
`define OPL3_MACROS_SVH

// ------------------------------
// Datapath widths
// ------------------------------

`define OPL_PHASE_W 20 // Phase accumulator width.
`define OPL_OUT_W 12 // Sample width.

// Sink buffer depth, which is also the number of credits at reset.
`define OPL_MAX_CREDITS 4

// ------------------------------
// Register map
// ------------------------------

`define OPL_ADDR_MULT 8'h20 // Bits 3:0 hold mult.
`define OPL_ADDR_FNUM_LO 8'hA0 // Low byte of fnum.

// fnum[9:8] in bits 1:0, block in bits 4:2, key-on in bit 5.
`define OPL_ADDR_FNUM_HI 8'hB0

`define OPL_ADDR_WS 8'hE0 // Bits 2:0 hold the waveform select.

`endif

// File: hw/opl3_operator.sv
`timescale 1ns/1ps

module opl3_operator (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  opl3_reg_pkg::reg_addr_t  wr_addr,
    input  opl3_reg_pkg::reg_data_t  wr_data,
    input  logic                     credit_return,
    output opl3_wave_pkg::sample_t   sample,
    output logic                     sample_valid
);

    import opl3_reg_pkg::*;
    import opl3_wave_pkg::*;

    // Decode to execute and result.
    fnum_t     fnum;
    block_t    block;
    mult_t     mult;
    logic      key_on;
    wave_sel_e ws;

    // Execute to result and back.
    phase_t phase;
    logic   phase_vld;
    logic   step;

    opl3_reg_decode u_reg_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .fnum    (fnum),
        .block   (block),
        .mult    (mult),
        .key_on  (key_on),
        .ws      (ws)
    );

    opl3_phase_gen u_phase_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .fnum      (fnum),
        .block     (block),
        .mult      (mult),
        .key_on    (key_on),
        .step      (step),
        .phase     (phase),
        .phase_vld (phase_vld)
    );

    opl3_wave_out u_wave_out (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_on        (key_on),
        .ws            (ws),
        .phase         (phase),
        .phase_vld     (phase_vld),
        .credit_return (credit_return),
        .step          (step),
        .sample        (sample),
        .sample_valid  (sample_valid)
    );

endmodule

// File: hw/opl3_phase_gen.sv
`timescale 1ns/1ps

module opl3_phase_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  opl3_reg_pkg::fnum_t     fnum,
    input  opl3_reg_pkg::block_t    block,
    input  opl3_reg_pkg::mult_t     mult,
    input  logic                    key_on,
    input  logic                    step,
    output opl3_wave_pkg::phase_t   phase,
    output logic                    phase_vld
);

    import opl3_wave_pkg::*;

    // ------------------------------
    // Increment pipeline
    // ------------------------------

    phase_t     pre_mult;    // Stage 1: fnum shifted by block.
    phase_t     post_mult;   // Stage 2: scaled by the multiplier table.
    phase_t     phase_inc;   // Stage 3: increment used by the accumulator.
    logic [3:0] mult_factor;

    // Codes 10 to 15 come in pairs, 1 to 9 scale by themselves.
    always_comb begin
        unique case (mult)
            4'd10, 4'd11: mult_factor = 4'd10;
            4'd12, 4'd13: mult_factor = 4'd12;
            4'd14, 4'd15: mult_factor = 4'd15;
            default:      mult_factor = mult;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_mult  <= '0;
            post_mult <= '0;
            phase_inc <= '0;
        end else begin
            pre_mult <= phase_t'(fnum) << block;
            if (mult == 4'd0) begin
                post_mult <= pre_mult >> 1; // Code 0 is one half.
            end else begin
                post_mult <= pre_mult * phase_t'(mult_factor); // Wraps to width.
            end
            phase_inc <= post_mult;
        end
    end

    // ------------------------------
    // Phase accumulator
    // ------------------------------

    phase_t acc;
    phase_t acc_cur;
    logic   key_on_q;
    logic   key_rise;

    assign key_rise = key_on && !key_on_q;

    // The first step after key-on may land in the edge cycle itself.
    assign acc_cur = key_rise ? '0 : acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_on_q  <= 1'b0;
            acc       <= '0;
            phase_vld <= 1'b0;
        end else begin
            key_on_q  <= key_on;
            phase_vld <= step;
            if (step) begin
                acc <= acc_cur + phase_inc;
            end else if (key_rise) begin
                acc <= '0;
            end
        end
    end

    // Phase sample, only meaningful with phase_vld.
    always_ff @(posedge clk) begin
        if (step) begin
            phase <= acc_cur;
        end
    end

    // Steps come from the result stage, which only issues them under key-on.
    a_vld_under_key_on: assert property (
        @(posedge clk) disable iff (!rst_n)
        phase_vld |-> $past(key_on)
    );

endmodule

// File: hw/opl3_reg_decode.sv
`timescale 1ns/1ps
`include "opl3_macros.svh"

module opl3_reg_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_en,
    input  opl3_reg_pkg::reg_addr_t   wr_addr,
    input  opl3_reg_pkg::reg_data_t   wr_data,
    output opl3_reg_pkg::fnum_t       fnum,
    output opl3_reg_pkg::block_t      block,
    output opl3_reg_pkg::mult_t       mult,
    output logic                      key_on,
    output opl3_wave_pkg::wave_sel_e  ws
);

    import opl3_reg_pkg::*;
    import opl3_wave_pkg::*;

    // ------------------------------
    // Address match
    // ------------------------------

    logic sel_mult;
    logic sel_fnum_lo;
    logic sel_fnum_hi;
    logic sel_ws;

    assign sel_mult    = wr_en && (wr_addr == `OPL_ADDR_MULT);
    assign sel_fnum_lo = wr_en && (wr_addr == `OPL_ADDR_FNUM_LO);
    assign sel_fnum_hi = wr_en && (wr_addr == `OPL_ADDR_FNUM_HI);
    assign sel_ws      = wr_en && (wr_addr == `OPL_ADDR_WS);

    // ------------------------------
    // Operator registers
    // ------------------------------

    // Unmatched addresses fall through and leave every field as it was.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fnum   <= '0;
            block  <= '0;
            mult   <= '0;
            key_on <= 1'b0;
            ws     <= WS_SAW;
        end else begin
            if (sel_mult) begin
                mult <= wr_data[3:0];
            end
            if (sel_fnum_lo) begin
                fnum[7:0] <= wr_data;
            end
            if (sel_fnum_hi) begin
                fnum[9:8] <= wr_data[1:0];
                block     <= wr_data[4:2];
                key_on    <= wr_data[5];
            end
            if (sel_ws) begin
                ws <= wave_sel_e'(wr_data[2:0]); // All eight codes are legal.
            end
        end
    end

    // A write with an unknown address could corrupt any field.
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr)
    );

endmodule

// File: hw/opl3_reg_pkg.sv
package opl3_reg_pkg;

    // ------------------------------
    // Operator parameter fields
    // ------------------------------

    // Frequency number, spread over two register writes.
    typedef logic [9:0] fnum_t;

    // Octave, applied as a left shift of fnum.
    typedef logic [2:0] block_t;

    // Multiplier code. The scale factor comes from a table,
    // not from the code itself.
    typedef logic [3:0] mult_t;

    // ------------------------------
    // Byte-wide write port
    // ------------------------------

    typedef logic [7:0] reg_addr_t; // Register address.
    typedef logic [7:0] reg_data_t; // Register data.

endpackage

// File: hw/opl3_wave_out.sv
`timescale 1ns/1ps
`include "opl3_macros.svh"

module opl3_wave_out (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       key_on,
    input  opl3_wave_pkg::wave_sel_e   ws,
    input  opl3_wave_pkg::phase_t      phase,
    input  logic                       phase_vld,
    input  logic                       credit_return,
    output logic                       step,
    output opl3_wave_pkg::sample_t     sample,
    output logic                       sample_valid
);

    import opl3_wave_pkg::*;

    localparam int CRED_W = $clog2(`OPL_MAX_CREDITS + 1);
    localparam int PW     = `OPL_PHASE_W;
    localparam int OW     = `OPL_OUT_W;

    localparam sample_t MOST_POS = {1'b0, {(OW - 1){1'b1}}};
    localparam sample_t MOST_NEG = {1'b1, {(OW - 1){1'b0}}};

    // ------------------------------
    // Credit counter
    // ------------------------------

    logic [CRED_W-1:0] credit_cnt;

    assign step = key_on && (credit_cnt != '0);

    // An issue and a return in one cycle cancel out.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CRED_W'(`OPL_MAX_CREDITS);
        end else if (step && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!step && credit_return) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Waveform shaping
    // ------------------------------

    sample_t saw;     // Top bits of the phase.
    sample_t saw_dbl; // Same at twice the rate.
    sample_t shaped;

    assign saw     = phase[PW-1 -: OW];
    assign saw_dbl = phase[PW-2 -: OW];

    always_comb begin
        unique case (ws)
            WS_SAW:     shaped = saw;
            WS_HALF:    shaped = saw[OW-1] ? '0 : saw;
            WS_ABS:     shaped = {1'b0, saw[OW-2:0]};
            WS_QUARTER: shaped = saw[OW-2] ? '0 : {1'b0, saw[OW-2:0]};
            WS_ALT:     shaped = saw[OW-1] ? '0 : saw_dbl;
            WS_ALT_ABS: shaped = saw[OW-1] ? '0 : {1'b0, saw_dbl[OW-2:0]};
            WS_SQUARE:  shaped = saw[OW-1] ? MOST_NEG : MOST_POS;
            WS_INV:     shaped = (saw == MOST_NEG) ? MOST_POS : -saw; // Saturate.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= phase_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (phase_vld) begin
            sample <= shaped;
        end
    end

    // The sink may never hand back more credits than it was given.
    a_credit_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        credit_cnt <= CRED_W'(`OPL_MAX_CREDITS)
    );

    // With no credit left and none returned, the next cycle stays idle.
    a_step_has_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        (credit_cnt == '0) && !credit_return |=> !step
    );

endmodule

// File: hw/opl3_wave_pkg.sv
`include "opl3_macros.svh"

package opl3_wave_pkg;

    // Unsigned phase, wraps modulo 2**OPL_PHASE_W.
    typedef logic [`OPL_PHASE_W-1:0] phase_t;

    // Signed output sample.
    typedef logic signed [`OPL_OUT_W-1:0] sample_t;

    // Waveform select codes, in register order.
    typedef enum logic [2:0] {
        WS_SAW,     // Plain sawtooth.
        WS_HALF,    // Negative half removed.
        WS_ABS,     // Sign cleared.
        WS_QUARTER, // Sign cleared, second quarter removed.
        WS_ALT,     // Double rate, first half only.
        WS_ALT_ABS, // Double rate, first half, sign cleared.
        WS_SQUARE,  // Full-scale square.
        WS_INV      // Negated sawtooth.
    } wave_sel_e;

endpackage

// File: tb/opl3_ref_model.svh
`ifndef OPL3_REF_MODEL_SVH
`define OPL3_REF_MODEL_SVH

// ------------------------------
// Random numbers
// ------------------------------

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

// ------------------------------
// Expected phase increment
// ------------------------------

function automatic phase_t ref_increment(input fnum_t f, input block_t b, input mult_t m);
    logic [31:0] pre;
    logic [31:0] scaled;
    pre = {22'd0, f} << b;
    case (m)
        4'd0:         scaled = pre >> 1; // One half.
        4'd10, 4'd11: scaled = pre * 10;
        4'd12, 4'd13: scaled = pre * 12;
        4'd14, 4'd15: scaled = pre * 15;
        default:      scaled = pre * m;
    endcase
    return scaled[`OPL_PHASE_W-1:0];
endfunction

// ------------------------------
// Expected sample
// ------------------------------

function automatic sample_t ref_sample(input phase_t ph, input wave_sel_e w);
    sample_t saw;
    sample_t dbl;
    sample_t lo_pos;
    sample_t lo_neg;
    saw    = sample_t'(ph >> (`OPL_PHASE_W - `OPL_OUT_W));
    dbl    = sample_t'((ph << 1) >> (`OPL_PHASE_W - `OPL_OUT_W));
    lo_pos = {1'b0, {(`OPL_OUT_W - 1){1'b1}}};
    lo_neg = {1'b1, {(`OPL_OUT_W - 1){1'b0}}};
    case (w)
        WS_SAW:     return saw;
        WS_HALF:    return (saw < 0) ? sample_t'(0) : saw;
        WS_ABS:     return saw & lo_pos;
        WS_QUARTER: return saw[`OPL_OUT_W-2] ? sample_t'(0) : (saw & lo_pos);
        WS_ALT:     return (saw < 0) ? sample_t'(0) : dbl;
        WS_ALT_ABS: return (saw < 0) ? sample_t'(0) : (dbl & lo_pos);
        WS_SQUARE:  return (saw < 0) ? lo_neg : lo_pos;
        default:    return (saw == lo_neg) ? lo_pos : sample_t'(-saw);
    endcase
endfunction

`endif

// File: tb/tb_opl3_operator.sv
`timescale 1ns/1ps
`include "opl3_macros.svh"

module tb_opl3_operator;

    import opl3_reg_pkg::*;
    import opl3_wave_pkg::*;

    `include "opl3_ref_model.svh"

    logic      clk;
    logic      rst_n;
    logic      wr_en;
    reg_addr_t wr_addr;
    reg_data_t wr_data;
    logic      credit_return;
    sample_t   sample;
    logic      sample_valid;

    logic [31:0] lcg_state = 32'hd4b4;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          rx_idx;     // Index of the next sample after key-on.
    int          rx_total;
    int          ret_total;
    phase_t      cur_inc;
    wave_sel_e   cur_ws;
    logic        long_stall;
    int          ret_delays[$];

    opl3_operator u_opl3_operator (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .credit_return (credit_return),
        .sample        (sample),
        .sample_valid  (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_next(lcg_state);
        return lcg_state >> 8;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic end_run();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // ------------------------------
    // Sink and checker
    // ------------------------------

    always @(negedge clk) begin
        sample_t exp;
        if (rst_n && sample_valid) begin
            exp = ref_sample(phase_t'(rx_idx) * cur_inc, cur_ws);
            checks++;
            if (sample !== exp) begin
                $display("[ERROR] sample: expected %h got %h at index %0d", exp, sample, rx_idx);
                errors++;
            end
            rx_idx++;
            rx_total++;
            if (long_stall && (rand_next() % 5 == 0)) begin
                ret_delays.push_back(15); // Long stall.
            end else begin
                ret_delays.push_back(rand_next() % 6);
            end
        end
        if (rx_total - ret_total > `OPL_MAX_CREDITS) begin
            $display("[ERROR] outstanding: limit %h got %h", `OPL_MAX_CREDITS,
                     rx_total - ret_total);
            errors++;
        end
    end

    // One credit per cycle at most and in arrival order.
    always @(posedge clk) begin
        #1;
        credit_return = 1'b0;
        if (ret_delays.size() > 0) begin
            if (ret_delays[0] == 0) begin
                void'(ret_delays.pop_front());
                credit_return = 1'b1;
                ret_total++;
            end else begin
                ret_delays[0] = ret_delays[0] - 1;
            end
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        wr_en   = 1'b1;
        wr_addr = a;
        wr_data = d;
        tick();
        wr_en = 1'b0;
    endtask

    task automatic key_cycle(input fnum_t f, input block_t b);
        int wait_cnt;
        rx_idx = 0;
        write_reg(`OPL_ADDR_FNUM_HI, {2'b00, 1'b1, b, f[9:8]});
        wait_cnt = 0;
        while (rx_idx < 32) begin
            tick();
            wait_cnt++;
            if (wait_cnt > 3000) begin
                $display("timeout: no sample arrived, got %0d of 32", rx_idx);
                errors++;
                end_run();
            end
        end
        write_reg(`OPL_ADDR_FNUM_HI, {2'b00, 1'b0, b, f[9:8]});
        repeat (4) tick(); // Let in-flight samples land.
        wait_cnt = 0;
        while (ret_total != rx_total || ret_delays.size() != 0) begin
            tick();
            wait_cnt++;
            if (wait_cnt > 500) begin
                $display("timeout: credits were not returned after key-off");
                errors++;
                end_run();
            end
        end
        tick();
    endtask

    task automatic run_seq(input fnum_t f, input block_t b, input mult_t m,
                           input wave_sel_e w);
        write_reg(`OPL_ADDR_MULT, {4'h0, m});
        write_reg(`OPL_ADDR_FNUM_LO, f[7:0]);
        write_reg(`OPL_ADDR_FNUM_HI, {2'b00, 1'b0, b, f[9:8]});
        write_reg(`OPL_ADDR_WS, {5'd0, w});
        cur_inc = ref_increment(f, b, m);
        cur_ws  = w;
        repeat (8) tick();
        key_cycle(f, b);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, errors - err_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        int   err0;
        int   idle;
        int   i;
        fnum_t f;
        rst_n         = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        credit_return = 1'b0;
        long_stall    = 1'b0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        rx_idx        = 0;
        rx_total      = 0;
        ret_total     = 0;
        cur_inc       = '0;
        cur_ws        = WS_SAW;
        repeat (16) tick();
        rst_n = 1'b1;
        tick();

        err0 = errors;
        idle = 0;
        while (idle < 20) begin
            checks++;
            if (sample_valid !== 1'b0) begin
                $display("[ERROR] sample_valid: expected %h got %h", 1'b0, sample_valid);
                errors++;
            end
            tick();
            idle++;
        end
        finish_test("idle after reset", err0);

        err0 = errors;
        run_seq(10'h155, 3'd0, 4'd1, WS_SAW);
        run_seq(10'h155, 3'd0, 4'd0, WS_SAW);
        run_seq(10'h3ff, 3'd0, 4'd10, WS_SAW);
        run_seq(10'h3ff, 3'd0, 4'd11, WS_SAW); // Shares the factor of code 10.
        run_seq(10'h3ff, 3'd0, 4'd13, WS_SAW);
        run_seq(10'h3ff, 3'd0, 4'd14, WS_SAW);
        run_seq(10'h3ff, 3'd0, 4'd15, WS_SAW);
        finish_test("multiplier table", err0);

        err0 = errors;
        for (i = 0; i < 8; i++) begin
            run_seq(10'h2a5, block_t'(i), 4'd1, WS_SAW);
        end
        finish_test("block shift", err0);

        err0 = errors;
        for (i = 0; i < 8; i++) begin
            f = fnum_t'(rand_next()) | 10'h200; // Top bit set so the phase visits every quadrant.
            run_seq(f, 3'd6, 4'd1, wave_sel_e'(i));
        end
        finish_test("waveforms", err0);

        err0 = errors;
        long_stall = 1'b1;
        run_seq(10'h1e3, 3'd6, 4'd3, WS_INV);
        run_seq(10'h0f7, 3'd7, 4'd2, WS_ALT);
        long_stall = 1'b0;
        finish_test("credit stalls", err0);

        err0 = errors;
        run_seq(10'h321, 3'd4, 4'd5, WS_HALF);
        key_cycle(10'h321, 3'd4); // Restart from phase zero.
        finish_test("key-on restart", err0);

        end_run();
    end

endmodule
